// ==== build.f ====
+incdir+.
adc_pkg.sv
adc_sample_packer.sv
adc_byte_fifo.sv
reg_adcfifo.sv
adc_capture_top.sv
tb_adc_capture.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_adc_capture

.PHONY: all run clean

all: run

$(SIM): build.f adc_consts.svh adc_pkg.sv adc_sample_packer.sv adc_byte_fifo.sv \
        reg_adcfifo.sv adc_capture_top.sv tb_adc_capture.sv
	verilator --binary --timing --assert --top-module tb_adc_capture -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_adc_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_consts.svh"

module tb_adc_capture
  import adc_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 4000;         // tests need well under half

  logic        clk_usb;
  logic        reset;
  reg_bus_t    reg_bus;
  logic [9:0]  adc_sample;
  logic        adc_valid;
  logic [7:0]  reg_datao;
  logic        segment_ready;

  logic [31:0] rng_state;                       // xorshift state
  logic [7:0]  exp_q[$];                        // bytes the fifo should hold
  int          pops;                            // successful pops so far
  int          uf_count;                        // pops on empty, saturating
  bit          uf_flag_on;                      // underflow flag unmasked
  bit          uf_sticky;
  bit          ov_sticky;
  bit          freeze_armed;                    // next error snapshots pops
  int          freeze_val;
  bit          low_res_m;                       // resolution as programmed
  bit          lsb_m;
  int          cycles = 0;

  adc_capture_top u_adc_capture_top (
    .clk_usb       (clk_usb),
    .reset         (reset),
    .reg_bus       (reg_bus),
    .adc_sample    (adc_sample),
    .adc_valid     (adc_valid),
    .reg_datao     (reg_datao),
    .segment_ready (segment_ready)
  );

  initial begin
    clk_usb = 1'b0;
    forever #50 clk_usb = ~clk_usb;             // 100 ns period
  end

  always @(posedge clk_usb) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "run aborted by timeout");
    end
  end

  task automatic fail_value(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  // compare is registered, so it is low one edge after any reset edge
  reset_clears_ready: assert property (@(posedge clk_usb) reset |=> !segment_ready)
    else fail_value("segment_ready during reset", 32'(segment_ready), 32'd0);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got == exp) else fail_value(what, {24'd0, got}, {24'd0, exp});
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got == exp) else fail_value(what, got, exp);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [6:0] bcnt,
                           input logic [7:0] data);
    @(negedge clk_usb);
    reg_bus.address = addr;
    reg_bus.bytecnt = bcnt;
    reg_bus.datai   = data;
    reg_bus.write   = 1'b1;
    @(negedge clk_usb);
    reg_bus.write   = 1'b0;                     // one edge with write high
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [6:0] bcnt,
                          output logic [7:0] data);
    @(negedge clk_usb);
    reg_bus.address = addr;
    reg_bus.bytecnt = bcnt;
    reg_bus.read    = 1'b1;
    @(negedge clk_usb);
    data = reg_datao;                           // slow pop lands on the next edge
    reg_bus.read = 1'b0;
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [31:0] word);
    for (int i = 0; i < 4; i++) begin
      write_reg(addr, 7'(i), word[i*8 +: 8]);
    end
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [31:0] word);
    logic [7:0] b;
    for (int i = 0; i < 4; i++) begin
      read_reg(addr, 7'(i), b);
      word[i*8 +: 8] = b;
    end
  endtask

  // first error after a clear freezes the pop count
  task automatic note_error();
    if (freeze_armed) begin
      freeze_val   = pops;
      freeze_armed = 1'b0;
    end
  endtask

  task automatic push_byte(input logic [7:0] data);
    if (exp_q.size() < `FIFO_DEPTH) begin
      exp_q.push_back(data);
    end else begin
      ov_sticky = 1'b1;                         // byte dropped
      note_error();
    end
  endtask

  task automatic feed_sample();
    logic [9:0] s;
    rng_state = xorshift(rng_state);
    s = rng_state[9:0];
    @(negedge clk_usb);
    adc_sample = s;
    adc_valid  = 1'b1;
    @(negedge clk_usb);
    adc_valid  = 1'b0;
    repeat (2) @(negedge clk_usb);              // three-cycle spacing
    if (!low_res_m) begin
      push_byte({6'b000000, s[9:8]});
      push_byte(s[7:0]);
    end else if (lsb_m) begin
      push_byte(s[7:0]);
    end else begin
      push_byte(s[9:2]);
    end
  endtask

  // one fifo read, slow through ADCREAD or fast on any address
  task automatic pop_byte(input bit fast);
    logic [7:0] got;
    if (fast) begin
      @(negedge clk_usb);
      got = reg_datao;                          // head is always on the bus
      reg_bus.address = 8'(`ADC_LOW_RES);
      reg_bus.read    = 1'b1;
      @(negedge clk_usb);
      reg_bus.read    = 1'b0;
    end else begin
      read_reg(8'(`ADCREAD_ADDR), 7'd0, got);
    end
    if (exp_q.size() == 0) begin
      if (uf_count < 255) begin
        uf_count++;
      end
      if (uf_flag_on) begin
        uf_sticky = 1'b1;
        note_error();
      end
    end else begin
      check_byte("fifo byte", got, exp_q.pop_front());
      pops++;
    end
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      pop_byte(1'b0);
    end
  endtask

  task automatic set_res(input bit low, input bit lsb);
    write_reg(8'(`ADC_LOW_RES), 7'd0, {6'b000000, lsb, low});
    low_res_m = low;
    lsb_m     = lsb;
  endtask

  task automatic clear_errors();
    write_reg(8'(`FIFO_STAT), 7'd0, 8'hff);
    uf_sticky    = 1'b0;
    ov_sticky    = 1'b0;
    freeze_armed = 1'b1;
  endtask

  task automatic check_stat();
    logic [7:0] b;
    read_reg(8'(`FIFO_STAT), 7'd0, b);
    check_byte("FIFO_STAT byte 0", b,
               {5'b00000, uf_sticky, ov_sticky, exp_q.size() == `FIFO_DEPTH});
    read_reg(8'(`FIFO_STAT), 7'd1, b);
    check_byte("FIFO_STAT byte 1", b, {7'b0000000, exp_q.size() == 0});
  endtask

  initial begin
    logic [7:0]  b;
    logic [31:0] w;
    reset      = 1'b1;
    reg_bus    = '0;
    adc_sample = '0;
    adc_valid  = 1'b0;
    rng_state  = 32'h64e105c9;
    pops       = 0;
    uf_count   = 0;
    uf_flag_on = 1'b0;                          // masked after reset
    uf_sticky  = 1'b0;
    ov_sticky  = 1'b0;
    freeze_armed = 1'b1;
    freeze_val = 0;
    low_res_m  = 1'b0;
    lsb_m      = 1'b0;
    repeat (10) @(posedge clk_usb);
    @(negedge clk_usb);
    reset = 1'b0;

    // values after reset
    check_byte("segment_ready after reset", {7'd0, segment_ready}, 8'd0);
    read_word(8'(`STREAM_SEGMENT_THRESHOLD), w);
    check_word("threshold after reset", w, 32'(`SEG_THRESH_RESET));
    read_reg(8'(`FIFO_NO_UNDERFLOW_ERROR), 7'd0, b);
    check_byte("FIFO_NO_UNDERFLOW_ERROR after reset", b, 8'd1);
    read_reg(8'(`FIFO_UNDERFLOW_COUNT), 7'd0, b);
    check_byte("underflow count after reset", b, 8'd0);
    check_stat();

    // full resolution, two bytes per sample
    set_res(1'b0, 1'b0);
    repeat (20) feed_sample();
    drain();
    check_stat();

    // low resolution, both windows
    set_res(1'b1, 1'b0);
    repeat (8) feed_sample();
    drain();
    set_res(1'b1, 1'b1);
    repeat (8) feed_sample();
    drain();

    // fast reads, then back to slow via another write
    repeat (6) feed_sample();
    write_reg(8'(`FAST_FIFO_READ_MODE), 7'd0, 8'd1);
    repeat (6) pop_byte(1'b1);
    set_res(1'b1, 1'b1);
    read_reg(8'(`ADC_LOW_RES), 7'd0, b);
    check_byte("ADC_LOW_RES after fast mode", b, 8'd3);
    check_stat();

    // underflow, masked and unmasked
    pop_byte(1'b0);
    read_reg(8'(`FIFO_UNDERFLOW_COUNT), 7'd0, b);
    check_byte("underflow count", b, 8'(uf_count));
    check_stat();
    write_reg(8'(`FIFO_NO_UNDERFLOW_ERROR), 7'd0, 8'd0);
    uf_flag_on = 1'b1;
    pop_byte(1'b0);
    check_stat();
    read_word(8'(`DEBUG_FIFO_READS_FREEZE), w);
    check_word("frozen pop count, underflow", w, 32'(freeze_val));
    read_word(8'(`DEBUG_FIFO_READS), w);
    check_word("pop count", w, 32'(pops));
    clear_errors();
    check_stat();

    // overflow past the depth
    set_res(1'b1, 1'b0);
    repeat (4) feed_sample();
    drain();                                    // pops after the clear shift the snapshot
    repeat (`FIFO_DEPTH + 2) feed_sample();
    check_stat();
    drain();
    read_word(8'(`DEBUG_FIFO_READS_FREEZE), w);
    check_word("frozen pop count, overflow", w, 32'(freeze_val));
    clear_errors();
    check_stat();

    // threshold readback and segment_ready
    write_word(8'(`STREAM_SEGMENT_THRESHOLD), 32'h12345678);
    read_word(8'(`STREAM_SEGMENT_THRESHOLD), w);
    check_word("threshold readback", w, 32'h12345678);
    write_word(8'(`STREAM_SEGMENT_THRESHOLD), 32'd10);
    read_word(8'(`STREAM_SEGMENT_THRESHOLD), w);
    check_word("threshold readback", w, 32'd10);
    repeat (12) begin
      feed_sample();
      check_byte("segment_ready", {7'd0, segment_ready}, {7'd0, exp_q.size() >= 10});
    end
    drain();
    read_word(8'(`DEBUG_FIFO_READS), w);
    check_word("final pop count", w, 32'(pops));

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== adc_capture_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top
  import adc_pkg::*;
(
  input  wire        clk_usb,
  input  wire        reset,
  input  reg_bus_t   reg_bus,           // host register access
  input  wire  [9:0] adc_sample,
  input  wire        adc_valid,
  output logic [7:0] reg_datao,
  output logic       segment_ready      // threshold reached
);

  adc_ctrl_t   adc_ctrl;                // resolution controls
  logic        wr_en;                   // packer byte strobe
  logic [7:0]  wr_data;
  logic [7:0]  fifo_data;               // show-ahead head
  fifo_stat_t  fifo_stat;
  logic [7:0]  underflow_count;
  fifo_count_t read_count;
  fifo_count_t read_count_freeze;
  logic        fifo_rd_en;
  logic        clear_fifo_errors;
  logic        no_underflow_errors;
  logic [31:0] stream_segment_threshold;

  adc_sample_packer u_adc_sample_packer (
    .clk_usb    (clk_usb),
    .reset      (reset),
    .adc_sample (adc_sample),
    .adc_valid  (adc_valid),
    .adc_ctrl   (adc_ctrl),
    .wr_en      (wr_en),
    .wr_data    (wr_data)
  );

  adc_byte_fifo u_adc_byte_fifo (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .wr_en                    (wr_en),
    .wr_data                  (wr_data),
    .fifo_rd_en               (fifo_rd_en),
    .clear_fifo_errors        (clear_fifo_errors),
    .no_underflow_errors      (no_underflow_errors),
    .stream_segment_threshold (stream_segment_threshold),
    .fifo_data                (fifo_data),
    .fifo_stat                (fifo_stat),
    .underflow_count          (underflow_count),
    .read_count               (read_count),
    .read_count_freeze        (read_count_freeze),
    .segment_ready            (segment_ready)
  );

  reg_adcfifo u_reg_adcfifo (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .reg_bus                  (reg_bus),
    .fifo_data                (fifo_data),
    .fifo_stat                (fifo_stat),
    .underflow_count          (underflow_count),
    .read_count               (read_count),
    .read_count_freeze        (read_count_freeze),
    .reg_datao                (reg_datao),
    .fifo_rd_en               (fifo_rd_en),
    .adc_ctrl                 (adc_ctrl),
    .fast_fifo_read_mode      (),       // internal to the register block
    .stream_segment_threshold (stream_segment_threshold),
    .clear_fifo_errors        (clear_fifo_errors),
    .no_underflow_errors      (no_underflow_errors)
  );

endmodule

`default_nettype wire

// ==== reg_adcfifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_consts.svh"

module reg_adcfifo
  import adc_pkg::*;
(
  input  wire         clk_usb,
  input  wire         reset,
  input  reg_bus_t    reg_bus,                  // host access
  input  wire  [7:0]  fifo_data,                // fifo head
  input  fifo_stat_t  fifo_stat,
  input  wire  [7:0]  underflow_count,
  input  fifo_count_t read_count,
  input  fifo_count_t read_count_freeze,
  output logic [7:0]  reg_datao,                // read data
  output logic        fifo_rd_en,               // pop strobe
  output adc_ctrl_t   adc_ctrl,
  output logic        fast_fifo_read_mode,
  output logic [31:0] stream_segment_threshold,
  output logic        clear_fifo_errors,
  output logic        no_underflow_errors
);

  logic        read_q;                          // read level, last cycle
  logic        write_q;                         // write level, last cycle
  logic        read_rise;                       // first cycle of a read
  logic        write_first;                     // first edge of a write
  logic        slow_rd_en;                      // registered pop
  logic [15:0] stat_word;                       // status padded to two bytes

  assign read_rise   = reg_bus.read && !read_q;
  assign write_first = reg_bus.write && !write_q;
  assign stat_word   = {7'b0000000, fifo_stat};

  // fast mode saves the register stage on the pop
  assign fifo_rd_en = fast_fifo_read_mode ? read_rise : slow_rd_en;

  // byte lane of a 32-bit register
  function automatic logic [7:0] pick_byte(input logic [31:0] word, input logic [1:0] idx);
    return word[idx*8 +: 8];
  endfunction

  // read mux
  always_comb begin
    if (fast_fifo_read_mode) begin
      reg_datao = fifo_data;                    // every read is a fifo read
    end else if (reg_bus.read) begin
      case (reg_bus.address)
        8'(`ADCREAD_ADDR):             reg_datao = fifo_data;
        8'(`FIFO_STAT):                reg_datao = stat_word[reg_bus.bytecnt[0]*8 +: 8];
        8'(`DEBUG_FIFO_READS):
          reg_datao = pick_byte(read_count, reg_bus.bytecnt[1:0]);
        8'(`DEBUG_FIFO_READS_FREEZE):
          reg_datao = pick_byte(read_count_freeze, reg_bus.bytecnt[1:0]);
        8'(`STREAM_SEGMENT_THRESHOLD):
          reg_datao = pick_byte(stream_segment_threshold, reg_bus.bytecnt[1:0]);
        8'(`ADC_LOW_RES):
          reg_datao = {6'b000000, adc_ctrl.low_res_lsb, adc_ctrl.low_res};
        8'(`FIFO_UNDERFLOW_COUNT):     reg_datao = underflow_count;
        8'(`FIFO_NO_UNDERFLOW_ERROR):  reg_datao = {7'b0000000, no_underflow_errors};
        default:                       reg_datao = 8'h00; // unmapped
      endcase
    end else begin
      reg_datao = 8'h00;                        // bus idle
    end
  end

  // level history for edge detect
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      read_q  <= reg_bus.read;
      write_q <= reg_bus.write;
    end
  end

  // control registers
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      adc_ctrl                 <= '0;
      stream_segment_threshold <= 32'(`SEG_THRESH_RESET);
      no_underflow_errors      <= 1'b1;         // slow underflow masked
      clear_fifo_errors        <= 1'b0;
    end else begin
      clear_fifo_errors <= 1'b0;                // one-cycle pulse
      if (write_first) begin
        case (reg_bus.address)
          8'(`ADC_LOW_RES): begin
            adc_ctrl.low_res     <= reg_bus.datai[0];
            adc_ctrl.low_res_lsb <= reg_bus.datai[1];
          end
          8'(`STREAM_SEGMENT_THRESHOLD):
            stream_segment_threshold[reg_bus.bytecnt[1:0]*8 +: 8] <= reg_bus.datai;
          8'(`FIFO_STAT):
            clear_fifo_errors <= 1'b1;          // any data clears
          8'(`FIFO_NO_UNDERFLOW_ERROR):
            no_underflow_errors <= reg_bus.datai[0];
          default: ;
        endcase
      end
    end
  end

  // fast mode, dropped by any other write
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_mode <= 1'b0;
    end else if (write_first) begin
      if (reg_bus.address == 8'(`FAST_FIFO_READ_MODE)) begin
        fast_fifo_read_mode <= reg_bus.datai[0];
      end else begin
        fast_fifo_read_mode <= 1'b0;
      end
    end
  end

  // slow pop, one cycle after the read starts
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      slow_rd_en <= 1'b0;
    end else begin
      slow_rd_en <= read_rise && (reg_bus.address == 8'(`ADCREAD_ADDR));
    end
  end

endmodule

`default_nettype wire

// ==== adc_byte_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_consts.svh"

module adc_byte_fifo
  import adc_pkg::*;
(
  input  wire         clk_usb,
  input  wire         reset,
  input  wire         wr_en,                    // byte from packer
  input  wire  [7:0]  wr_data,
  input  wire         fifo_rd_en,               // pop request
  input  wire         clear_fifo_errors,        // clears sticky flags
  input  wire         no_underflow_errors,      // masks underflow flag
  input  wire  [31:0] stream_segment_threshold,
  output logic [7:0]  fifo_data,                // show-ahead head
  output fifo_stat_t  fifo_stat,
  output logic [7:0]  underflow_count,
  output fifo_count_t read_count,
  output fifo_count_t read_count_freeze,
  output logic        segment_ready
);

  logic [7:0]         mem [0:`FIFO_DEPTH-1];    // byte storage
  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   level;                   // 0 to depth inclusive
  logic               empty;
  logic               full;
  logic               do_write;                 // accepted write
  logic               do_pop;                   // successful pop
  logic               overflow_evt;             // write into full fifo
  logic               underflow_evt;            // pop on empty
  logic               underflow_flag_evt;       // unmasked underflow
  logic               overflow_sticky;
  logic               underflow_sticky;
  logic               freeze_armed;             // waiting for first error

  assign empty              = (level == '0);
  assign full               = (level == (`FIFO_AW+1)'(`FIFO_DEPTH));
  assign do_write           = wr_en && !full;
  assign do_pop             = fifo_rd_en && !empty;
  assign overflow_evt       = wr_en && full;     // byte dropped
  assign underflow_evt      = fifo_rd_en && empty;
  assign underflow_flag_evt = underflow_evt && !no_underflow_errors;

  assign fifo_data = mem[rd_ptr];               // head visible without a pop

  always_comb begin
    fifo_stat                  = '0;
    fifo_stat.empty            = empty;
    fifo_stat.full             = full;
    fifo_stat.overflow_sticky  = overflow_sticky;
    fifo_stat.underflow_sticky = underflow_sticky;
  end

  // storage, no reset
  always_ff @(posedge clk_usb) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers and level
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;                // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;                // both or neither
      endcase
    end
  end

  // error flags and counters
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      overflow_sticky   <= 1'b0;
      underflow_sticky  <= 1'b0;
      underflow_count   <= '0;
      read_count        <= '0;
      read_count_freeze <= '0;
      freeze_armed      <= 1'b1;
    end else begin
      if (clear_fifo_errors) begin
        overflow_sticky  <= 1'b0;
        underflow_sticky <= 1'b0;
        freeze_armed     <= 1'b1;               // next error snapshots again
      end
      if (overflow_evt) begin
        overflow_sticky <= 1'b1;                // new error wins over clear
      end
      if (underflow_flag_evt) begin
        underflow_sticky <= 1'b1;
      end
      if (underflow_evt && (underflow_count != 8'hff)) begin
        underflow_count <= underflow_count + 1'b1; // saturates at 255
      end
      if (do_pop) begin
        read_count <= read_count + 1'b1;
      end
      if ((overflow_evt || underflow_flag_evt) && freeze_armed) begin
        read_count_freeze <= read_count;        // pops before the error
        freeze_armed      <= 1'b0;
      end
    end
  end

  // segment threshold compare, registered
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      segment_ready <= 1'b0;
    end else begin
      segment_ready <= ({{(31-`FIFO_AW){1'b0}}, level} >= stream_segment_threshold);
    end
  end

endmodule

`default_nettype wire

// ==== adc_sample_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_sample_packer
  import adc_pkg::*;
(
  input  wire        clk_usb,
  input  wire        reset,
  input  wire  [9:0] adc_sample,    // raw adc code
  input  wire        adc_valid,     // one-cycle sample strobe
  input  adc_ctrl_t  adc_ctrl,      // resolution controls
  output logic       wr_en,         // one pulse per byte
  output logic [7:0] wr_data        // byte to fifo
);

  logic [9:0] sample_q;             // accepted sample
  logic       pending_lo;           // low byte still owed
  logic       accept;               // sample taken this edge
  logic [7:0] first_byte;           // byte emitted after accept

  // no back-pressure, a sample during the low byte is lost
  assign accept = adc_valid && !pending_lo;

  // resolution is sampled at acceptance
  always_comb begin
    if (adc_ctrl.low_res) begin
      if (adc_ctrl.low_res_lsb) begin
        first_byte = adc_sample[7:0];           // lsb window
      end else begin
        first_byte = adc_sample[9:2];           // top eight bits
      end
    end else begin
      first_byte = {6'b000000, adc_sample[9:8]}; // high byte first
    end
  end

  // control path
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_en      <= 1'b0;
      pending_lo <= 1'b0;
    end else begin
      wr_en <= 1'b0;                            // default idle
      if (pending_lo) begin
        wr_en      <= 1'b1;                     // low byte out
        pending_lo <= 1'b0;
      end else if (accept) begin
        wr_en      <= 1'b1;                     // first byte out
        pending_lo <= !adc_ctrl.low_res;        // full res owes one more
      end
    end
  end

  // sample and byte registers
  always_ff @(posedge clk_usb) begin
    if (accept) begin
      sample_q <= adc_sample;
    end
    if (pending_lo) begin
      wr_data <= sample_q[7:0];                 // second byte of full res
    end else if (accept) begin
      wr_data <= first_byte;
    end
  end

endmodule

`default_nettype wire

// ==== adc_pkg.sv ====
`default_nettype none

package adc_pkg;

  // host register access, held for one access
  typedef struct packed {
    logic [7:0] address;           // register address
    logic [6:0] bytecnt;           // byte of a wide register
    logic [7:0] datai;             // write data
    logic       read;              // read level
    logic       write;             // write level
  } reg_bus_t;

  // resolution controls for the packer
  typedef struct packed {
    logic low_res;                 // one byte per sample
    logic low_res_lsb;             // take sample[7:0] instead of [9:2]
  } adc_ctrl_t;

  // status word, byte 1 is empty, byte 0 the rest
  typedef struct packed {
    logic       empty;             // byte 1, bit 0
    logic [4:0] reserved;          // reads as zero
    logic       underflow_sticky;  // pop while empty, unless masked
    logic       overflow_sticky;   // write while full
    logic       full;              // level at depth
  } fifo_stat_t;

  // debug pop counters
  typedef logic [31:0] fifo_count_t;

endpackage

`default_nettype wire

// ==== adc_consts.svh ====
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

// fifo geometry
`define FIFO_DEPTH 64              // bytes of sample storage
`define FIFO_AW 6                  // pointer width, log2 of depth

// threshold after reset, well above the fifo depth
`define SEG_THRESH_RESET 65536

// register map, byte-wide host bus
`define ADCREAD_ADDR 3             // fifo head, pops on read
`define FIFO_STAT 6                // status, write clears sticky flags
`define ADC_LOW_RES 8              // bit0 low_res, bit1 low_res_lsb
`define STREAM_SEGMENT_THRESHOLD 9 // 32 bits, byte per bytecnt
`define FAST_FIFO_READ_MODE 10     // bit0 enables fast pops
`define FIFO_UNDERFLOW_COUNT 11    // saturating pop-on-empty count
`define FIFO_NO_UNDERFLOW_ERROR 12 // bit0 masks the underflow flag
`define DEBUG_FIFO_READS 13        // 32-bit successful pop count
`define DEBUG_FIFO_READS_FREEZE 14 // pop count at first error

`endif
